//--- fis_receive_top.f
+incdir+src
src/fis_rx_pkg.sv
src/fis_stream_rx.sv
src/tfd_sig_regs.sv
src/reg_write_arb.sv
src/fis_receive_top.sv
tb/tb_clock_gen.sv
tb/fis_receive_tb.sv

//--- run_sim.sh
#!/bin/sh
# Builds the FIS receive testbench with Verilator and runs it from the project root.
# Exit status is 0 only when the run prints the pass message.
cd "$(dirname "$0")" || exit 1
verilator --binary --timing -Wno-fatal --top-module fis_receive_tb \
    -f fis_receive_top.f -o fis_receive_sim \
    && ./obj_dir/fis_receive_sim | tee /dev/stderr | grep -q "ALL TESTS PASSED" \
    && echo "simulation passed" \
    || { echo "simulation failed"; exit 1; }

//--- src/fis_receive_top.sv
// AHCI port FIS receive path.
// The FIFO storer and the task-file unit share one register write port,
// the storer having priority; host command writes may be delayed while a FIS is stored.
// Inputs are sampled on the rising edge of mclk, hba_rst is synchronous.
`timescale 1ns/1ps

module fis_receive_top (
    input  logic                  mclk,
    input  logic                  hba_rst,
    input  logic                  in_valid,
    input  fis_rx_pkg::in_dword_t in_dword,
    output logic                  in_ready,
    input  logic                  get_valid,
    input  fis_rx_pkg::fis_kind_e get_kind,
    input  logic                  pcmd_fre,
    output logic                  fis_first_vld,
    output logic                  get_fis_busy,
    output logic                  get_fis_done,
    output logic                  fis_ok,
    output logic                  fis_err,
    output logic                  fis_ferr,
    input  logic                  update_sig,
    input  logic                  set_update_sig,
    input  logic                  update_err_sts,
    input  logic                  set_bsy,
    input  logic                  clear_bsy_drq,
    output logic                  sig_pending,
    output logic                  sig_available,
    output fis_rx_pkg::tfd_t      tfd,
    output logic [7:0]            pio_es,
    output logic                  reg_we,
    output fis_rx_pkg::reg_wr_t   reg_wr
);
    import fis_rx_pkg::*;

    logic       dw_valid;        // storer to task-file unit
    stored_dw_t stored_dw;
    logic [1:0] arb_valid;       // 0 storer, 1 task-file unit
    logic [1:0] arb_ready;
    reg_wr_t    arb_req [2];

    fis_stream_rx u_stream (
        .mclk          (mclk),
        .hba_rst       (hba_rst),
        .in_valid      (in_valid),
        .in_dword      (in_dword),
        .in_ready      (in_ready),
        .get_valid     (get_valid),
        .get_kind      (get_kind),
        .pcmd_fre      (pcmd_fre),
        .sig_pending   (sig_pending),
        .fis_first_vld (fis_first_vld),
        .get_fis_busy  (get_fis_busy),
        .get_fis_done  (get_fis_done),
        .fis_ok        (fis_ok),
        .fis_err       (fis_err),
        .fis_ferr      (fis_ferr),
        .dw_valid      (dw_valid),
        .stored_dw     (stored_dw),
        .wr_valid      (arb_valid[0]),
        .wr_req        (arb_req[0]),
        .wr_ready      (arb_ready[0])
    );

    tfd_sig_regs u_tfd (
        .mclk           (mclk),
        .hba_rst        (hba_rst),
        .dw_valid       (dw_valid),
        .stored_dw      (stored_dw),
        .update_sig     (update_sig),
        .set_update_sig (set_update_sig),
        .update_err_sts (update_err_sts),
        .set_bsy        (set_bsy),
        .clear_bsy_drq  (clear_bsy_drq),
        .sig_pending    (sig_pending),
        .sig_available  (sig_available),
        .tfd            (tfd),
        .pio_es         (pio_es),
        .wr_valid       (arb_valid[1]),
        .wr_req         (arb_req[1]),
        .wr_ready       (arb_ready[1])
    );

    reg_write_arb #(
        .N_REQ (2)
    ) u_arb (
        .mclk      (mclk),
        .hba_rst   (hba_rst),
        .req_valid (arb_valid),
        .req       (arb_req),
        .req_ready (arb_ready),
        .reg_we    (reg_we),
        .reg_wr    (reg_wr)
    );

endmodule

//--- src/fis_rx_params.svh
// Register map and FIS length constants for the AHCI FIS receive path.
// All addresses are dword addresses in a 10-bit register space.
// Lengths count the dwords of each FIS kind, header included, end marker excluded.
// IGNORE has no save slot, so it only consumes dwords.
`ifndef FIS_RX_PARAMS_SVH
`define FIS_RX_PARAMS_SVH

// register dword address width
`define FIS_ADDR_BITS   10

// received-FIS area, port 0
`define FB_OFFS32       'h300    // base of the received-FIS area
`define PSFIS_OFFS32    'h8      // PIO setup slot
`define RFIS_OFFS32     'h10     // D2H register slot
`define SDBFIS_OFFS32   'h16     // set device bits slot

// port 0 task-file and signature registers
`define PXTFD_OFFS32    'h48     // PxTFD: err in 15:8, sts in 7:0
`define PXSIG_OFFS32    'h49     // PxSIG

// dwords consumed per kind
`define RFIS_LEN        5
`define PSFIS_LEN       5
`define SDBFIS_LEN      2
`define IGNORE_LEN      16       // longest FIS accepted before a fatal error

`endif

//--- src/fis_rx_pkg.sv
// Types shared by the FIS receive path and its testbench.
// The dword tag encoding matches the transport-layer FIFO output.
`include "fis_rx_params.svh"

package fis_rx_pkg;

    // tag travelling with each FIFO dword
    typedef enum logic [1:0] {
        DATA     = 2'd0,     // FIS body dword
        FIS_HEAD = 2'd1,     // first dword, FIS type in the low byte
        R_OK     = 2'd2,     // end marker, crc good
        R_ERR    = 2'd3      // end marker, crc or link error
    } in_type_e;

    typedef struct packed {
        logic [31:0] data;
        in_type_e    tag;
    } in_dword_t;            // 34 bits

    // what the host asks the receiver to do with the next FIS
    typedef enum logic [1:0] {
        RFIS,                // D2H register
        PSFIS,               // PIO setup
        SDBFIS,              // set device bits
        IGNORE               // consume and drop
    } fis_kind_e;

    typedef struct packed {
        logic [`FIS_ADDR_BITS-1:0] addr;
        logic [31:0]               data;
    } reg_wr_t;              // 42 bits

    typedef struct packed {
        fis_kind_e   kind;
        logic [3:0]  idx;    // dword position inside the FIS
        logic [31:0] data;
    } stored_dw_t;           // 38 bits

    typedef struct packed {
        logic [7:0] err;
        logic [7:0] sts;     // bit 7 BSY, bit 3 DRQ, bit 0 ERR
    } tfd_t;

endpackage

//--- src/fis_stream_rx.sv
// FIS framing and storage for the receive FIFO.
// A get command is taken only while get_fis_busy is low; other gets are dropped.
// The FIS header is dword 0 and is consumed as part of the FIS.
// Each saved dword becomes one register write request, held until granted.
// An overrun dword is consumed, raises fis_ferr and ends the FIS without a write;
// its end marker is then left in the FIFO for the host to handle.
`timescale 1ns/1ps
`include "fis_rx_params.svh"

module fis_stream_rx (
    input  logic                   mclk,
    input  logic                   hba_rst,
    input  logic                   in_valid,
    input  fis_rx_pkg::in_dword_t  in_dword,
    output logic                   in_ready,
    input  logic                   get_valid,
    input  fis_rx_pkg::fis_kind_e  get_kind,
    input  logic                   pcmd_fre,
    input  logic                   sig_pending,
    output logic                   fis_first_vld,
    output logic                   get_fis_busy,
    output logic                   get_fis_done,
    output logic                   fis_ok,
    output logic                   fis_err,
    output logic                   fis_ferr,
    output logic                   dw_valid,
    output fis_rx_pkg::stored_dw_t stored_dw,
    output logic                   wr_valid,
    output fis_rx_pkg::reg_wr_t    wr_req,
    input  logic                   wr_ready
);
    import fis_rx_pkg::*;

    fis_kind_e                 kind_r;      // kind of the running FIS
    logic                      save_r;      // dwords go to the received-FIS area
    logic [4:0]                rem_cnt;     // dwords still expected
    logic [3:0]                idx_r;       // position of the next dword
    logic [`FIS_ADDR_BITS-1:0] addr_r;      // next save address
    logic                      save_nxt;
    logic                      get_acc;
    logic                      consume;
    logic                      is_end;
    logic                      end_take;
    logic                      take_dw;
    logic                      overrun;

    function automatic logic [4:0] kind_len(fis_kind_e k);
        case (k)
            RFIS:    kind_len = 5'(`RFIS_LEN);
            PSFIS:   kind_len = 5'(`PSFIS_LEN);
            SDBFIS:  kind_len = 5'(`SDBFIS_LEN);
            default: kind_len = 5'(`IGNORE_LEN);
        endcase
    endfunction

    function automatic logic [`FIS_ADDR_BITS-1:0] kind_addr(fis_kind_e k);
        case (k)
            RFIS:    kind_addr = `FIS_ADDR_BITS'(`FB_OFFS32 + `RFIS_OFFS32);
            PSFIS:   kind_addr = `FIS_ADDR_BITS'(`FB_OFFS32 + `PSFIS_OFFS32);
            SDBFIS:  kind_addr = `FIS_ADDR_BITS'(`FB_OFFS32 + `SDBFIS_OFFS32);
            default: kind_addr = `FIS_ADDR_BITS'(`FB_OFFS32); // never written
        endcase
    endfunction

    // signature FIS is kept while the host waits for it, even with fre off
    always_comb begin
        case (get_kind)
            RFIS:          save_nxt = sig_pending || pcmd_fre;
            PSFIS, SDBFIS: save_nxt = pcmd_fre;
            default:       save_nxt = 1'b0;
        endcase
    end

    assign get_acc  = get_valid && !get_fis_busy;
    assign in_ready = get_fis_busy && (!wr_valid || wr_ready); // stall on an ungranted write
    assign consume  = in_valid && in_ready;
    assign is_end   = (in_dword.tag == R_OK) || (in_dword.tag == R_ERR);
    assign end_take = consume && is_end;
    assign take_dw  = consume && !is_end && (rem_cnt != 5'd0);
    assign overrun  = consume && !is_end && (rem_cnt == 5'd0); // FIS longer than its kind

    always_ff @(posedge mclk) begin
        if (hba_rst) begin
            get_fis_busy  <= 1'b0;
            get_fis_done  <= 1'b0;
            fis_ok        <= 1'b0;
            fis_err       <= 1'b0;
            fis_ferr      <= 1'b0;
            fis_first_vld <= 1'b0;
            dw_valid      <= 1'b0;
            wr_valid      <= 1'b0;
            kind_r        <= IGNORE;
            save_r        <= 1'b0;
            rem_cnt       <= 5'd0;
            idx_r         <= 4'd0;
        end else begin
            get_fis_done <= end_take || overrun;
            dw_valid     <= take_dw;                         // every body dword, saved or not
            if (get_acc) begin
                get_fis_busy <= 1'b1;
                kind_r       <= get_kind;
                save_r       <= save_nxt;
                rem_cnt      <= kind_len(get_kind);
                idx_r        <= 4'd0;
            end else if (end_take || overrun) begin
                get_fis_busy <= 1'b0;
            end else if (take_dw) begin
                rem_cnt <= rem_cnt - 5'd1;
                idx_r   <= idx_r + 4'd1;
            end
            if (get_acc) begin
                fis_ok  <= 1'b0;
                fis_err <= 1'b0;
            end else if (end_take) begin
                fis_ok  <= in_dword.tag == R_OK;
                fis_err <= in_dword.tag == R_ERR;
            end
            if (overrun) fis_ferr <= 1'b1;                   // fatal, cleared by reset only
            if (get_acc) begin
                fis_first_vld <= 1'b0;
            end else if (in_valid && !get_fis_busy && (in_dword.tag == FIS_HEAD)) begin
                fis_first_vld <= 1'b1;                       // header waiting to be decoded
            end
            if (take_dw && save_r) begin
                wr_valid <= 1'b1;
            end else if (wr_ready) begin
                wr_valid <= 1'b0;
            end
        end
    end

    always_ff @(posedge mclk) begin
        if (get_acc) begin
            addr_r <= kind_addr(get_kind);
        end else if (take_dw && save_r) begin
            addr_r <= addr_r + `FIS_ADDR_BITS'(1);
        end
        if (take_dw) begin
            stored_dw <= '{kind: kind_r, idx: idx_r, data: in_dword.data};
        end
        if (take_dw && save_r) begin
            wr_req <= '{addr: addr_r, data: in_dword.data};
        end
    end

endmodule

//--- src/reg_write_arb.sv
// Fixed-priority arbiter for the register write port, lowest index wins.
// req_ready is combinational from req_valid, so a request is granted in the
// cycle it is seen unless a lower index also asks.
// The granted write appears on reg_we/reg_wr one cycle after the handshake.
// The register side never stalls.
`timescale 1ns/1ps

module reg_write_arb #(
    parameter int N_REQ = 2
) (
    input  logic                mclk,
    input  logic                hba_rst,
    input  logic [N_REQ-1:0]    req_valid,
    input  fis_rx_pkg::reg_wr_t req [N_REQ],
    output logic [N_REQ-1:0]    req_ready,
    output logic                reg_we,
    output fis_rx_pkg::reg_wr_t reg_wr
);
    localparam int IDX_W = (N_REQ > 1) ? $clog2(N_REQ) : 1;

    logic [N_REQ-1:0] gnt;       // one-hot grant
    logic [IDX_W-1:0] gnt_idx;   // index of the granted requester

    // scan from the top so the lowest valid index is left standing
    always_comb begin
        gnt     = '0;
        gnt_idx = '0;
        for (int i = N_REQ - 1; i >= 0; i--) begin
            if (req_valid[i]) begin
                gnt     = '0;
                gnt[i]  = 1'b1;
                gnt_idx = IDX_W'(i);
            end
        end
    end

    assign req_ready = gnt;

    always_ff @(posedge mclk) begin
        if (hba_rst) begin
            reg_we <= 1'b0;
        end else begin
            reg_we <= |gnt;                                  // one write per cycle at most
        end
    end

    always_ff @(posedge mclk) begin
        if (|gnt) reg_wr <= req[gnt_idx];
    end

endmodule

//--- src/tfd_sig_regs.sv
// Task-file, signature and PIO E_Status capture for one port.
// Fields are taken from body dwords of every received FIS, saved or not.
// Host commands take effect on the next edge, and the resulting register write
// waits in a single slot for the arbiter; a newer command replaces a waiting write.
// When a PxTFD and a PxSIG command come together, the PxTFD write is kept.
`timescale 1ns/1ps
`include "fis_rx_params.svh"

module tfd_sig_regs (
    input  logic                   mclk,
    input  logic                   hba_rst,
    input  logic                   dw_valid,
    input  fis_rx_pkg::stored_dw_t stored_dw,
    input  logic                   update_sig,
    input  logic                   set_update_sig,
    input  logic                   update_err_sts,
    input  logic                   set_bsy,
    input  logic                   clear_bsy_drq,
    output logic                   sig_pending,
    output logic                   sig_available,
    output fis_rx_pkg::tfd_t       tfd,
    output logic [7:0]             pio_es,
    output logic                   wr_valid,
    output fis_rx_pkg::reg_wr_t    wr_req,
    input  logic                   wr_ready
);
    import fis_rx_pkg::*;

    logic [31:0] sig_r;          // device signature from the last D2H FIS
    tfd_t        tfd_nxt;
    logic        rfis_dw;
    logic        psfis_dw;
    logic        sdbfis_dw;
    logic        cmd_tfd;        // command that rewrites PxTFD
    logic        cmd_sig;        // signature write actually requested

    assign rfis_dw   = dw_valid && (stored_dw.kind == RFIS);
    assign psfis_dw  = dw_valid && (stored_dw.kind == PSFIS);
    assign sdbfis_dw = dw_valid && (stored_dw.kind == SDBFIS);
    assign cmd_tfd   = update_err_sts || set_bsy || clear_bsy_drq;
    assign cmd_sig   = update_sig && sig_pending;

    // capture first, host bit commands on top of it
    always_comb begin
        tfd_nxt = tfd;
        if (rfis_dw && (stored_dw.idx == 4'd0)) begin
            tfd_nxt = stored_dw.data[15:0];                  // err high byte, sts low byte
        end else if (psfis_dw && (stored_dw.idx == 4'd0)) begin
            tfd_nxt.err = stored_dw.data[31:24];
            tfd_nxt.sts = stored_dw.data[23:16];
        end else if (sdbfis_dw && (stored_dw.idx == 4'd0)) begin
            tfd_nxt.err      = stored_dw.data[15:8];
            tfd_nxt.sts[6:4] = stored_dw.data[6:4];          // BSY and DRQ stay as they are
            tfd_nxt.sts[2:0] = stored_dw.data[2:0];
        end
        if (clear_bsy_drq) begin
            tfd_nxt.sts[7] = 1'b0;
            tfd_nxt.sts[3] = 1'b0;
        end
        if (set_bsy) tfd_nxt.sts[7] = 1'b1;
    end

    always_ff @(posedge mclk) begin
        if (hba_rst) begin
            tfd           <= '0;
            pio_es        <= 8'd0;
            sig_pending   <= 1'b1;                           // first D2H after reset is the signature
            sig_available <= 1'b0;
            wr_valid      <= 1'b0;
        end else begin
            tfd <= tfd_nxt;
            if (psfis_dw && (stored_dw.idx == 4'd3)) pio_es <= stored_dw.data[31:24];
            if (set_update_sig) begin
                sig_pending <= 1'b1;
            end else if (update_sig) begin
                sig_pending <= 1'b0;
            end
            if (cmd_sig) begin
                sig_available <= 1'b0;
            end else if (rfis_dw && (stored_dw.idx == 4'd3)) begin
                sig_available <= 1'b1;                       // last signature byte in
            end
            if (cmd_tfd || cmd_sig) begin
                wr_valid <= 1'b1;
            end else if (wr_ready) begin
                wr_valid <= 1'b0;
            end
        end
    end

    always_ff @(posedge mclk) begin
        if (rfis_dw && (stored_dw.idx == 4'd1)) sig_r[31:8] <= stored_dw.data[23:0];
        if (rfis_dw && (stored_dw.idx == 4'd3)) sig_r[7:0]  <= stored_dw.data[7:0];
        if (cmd_tfd) begin
            wr_req <= '{addr: `FIS_ADDR_BITS'(`PXTFD_OFFS32), data: {16'd0, tfd_nxt}};
        end else if (cmd_sig) begin
            wr_req <= '{addr: `FIS_ADDR_BITS'(`PXSIG_OFFS32), data: sig_r};
        end
    end

endmodule

//--- tb/fis_receive_tb.sv
// Testbench for the AHCI FIS receive path.
// Each record of tb/fis_testdata.txt is one FIS or one host command with its
// expected register writes, tfd, pio_es and status flags.
// Inputs change 1 ns after the rising edge; outputs are read at the falling edge
// or once the inputs have been updated. in_valid gaps come from a fixed-seed LFSR.
// A FIS cut short by an overrun leaves its remaining dwords undelivered.
`timescale 1ns/1ps

module fis_receive_tb;
    import fis_rx_pkg::*;

    localparam int MEM_WORDS = 512;

    logic        mclk;
    logic        hba_rst;
    logic        in_valid;
    in_dword_t   in_dword;
    logic        in_ready;
    logic        get_valid;
    fis_kind_e   get_kind;
    logic        pcmd_fre;
    logic        fis_first_vld;
    logic        get_fis_busy;
    logic        get_fis_done;
    logic        fis_ok;
    logic        fis_err;
    logic        fis_ferr;
    logic        update_sig;
    logic        set_update_sig;
    logic        update_err_sts;
    logic        set_bsy;
    logic        clear_bsy_drq;
    logic        sig_pending;
    logic        sig_available;
    tfd_t        tfd;
    logic [7:0]  pio_es;
    logic        reg_we;
    reg_wr_t     reg_wr;

    logic [31:0] tdata [MEM_WORDS];                  // raw test records
    logic [31:0] lfsr = 32'h6e6f9371;
    logic [8:0]  rst_bits;
    int          errors = 0;
    int          tests = 0;
    int          cyc = 0;                            // rising edges since time 0
    int          limit = 0;
    int          done_cnt = 0;
    int          p;
    int          n_dw;
    int          total;
    logic [9:0]  wr_addr_q [$];
    logic [31:0] wr_data_q [$];
    int          wr_cyc_q [$];
    int          ref_cyc_q [$];                      // cycle of the dword or command behind each write
    string       kind_names [4] = '{"rfis", "psfis", "sdbfis", "ignore"};
    string       cmd_names [5] = '{"set_bsy", "clear_bsy_drq", "update_sig",
                                   "update_err_sts", "set_update_sig"};

    tb_clock_gen u_clk (
        .mclk    (mclk),
        .hba_rst (hba_rst)
    );

    fis_receive_top DUT (.*);

    // x^32 + x^22 + x^2 + x + 1 with the new bit shifted in at bit 0
    function automatic logic [31:0] lfsr_next(logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    task automatic report_mismatch(string name, string what, logic [31:0] exp,
                                   logic [31:0] act);
        errors++;
        $display("CHECK FAILED %s %s: expected %h, actual %h", name, what, exp, act);
    endtask

    task automatic report_problem(string msg);
        errors++;
        $display("ERROR %s", msg);
    endtask

    task automatic step_cycle();
        @(posedge mclk);
        #1;
    endtask

    // x indexes the expected write count; state words follow the write pairs
    task automatic check_result(string name, int x);
        int          nwr;
        int          s;
        logic [31:0] flags;
        nwr   = tdata[x];
        s     = x + 1 + 2 * nwr;
        flags = {27'd0, sig_pending, sig_available, fis_ferr, fis_err, fis_ok};
        if (wr_addr_q.size() != nwr) report_mismatch(name, "write count", nwr, wr_addr_q.size());
        for (int i = 0; i < nwr && i < wr_addr_q.size(); i++) begin
            if (wr_addr_q[i] !== tdata[x+1+2*i][9:0]) begin
                report_mismatch(name, "write address", tdata[x+1+2*i], {22'd0, wr_addr_q[i]});
            end
            if (wr_data_q[i] !== tdata[x+2+2*i]) begin
                report_mismatch(name, "write data", tdata[x+2+2*i], wr_data_q[i]);
            end
            if (i < ref_cyc_q.size() && (wr_cyc_q[i] - ref_cyc_q[i] != 2)) begin
                report_mismatch(name, "write latency", 2, wr_cyc_q[i] - ref_cyc_q[i]);
            end
        end
        if (tfd !== tdata[s][15:0]) report_mismatch(name, "tfd", tdata[s], {16'd0, tfd});
        if (pio_es !== tdata[s+1][7:0]) report_mismatch(name, "pio_es", tdata[s+1], {24'd0, pio_es});
        if (flags !== tdata[s+2]) report_mismatch(name, "flags", tdata[s+2], flags);
        if (get_fis_busy !== 1'b0) report_mismatch(name, "get_fis_busy", 0, {31'd0, get_fis_busy});
        wr_addr_q.delete();
        wr_data_q.delete();
        wr_cyc_q.delete();
        ref_cyc_q.delete();
    endtask

    task automatic run_fis(string name, int r);
        int n;
        int e;
        int waited;
        int done_at_start;
        bit consumed;
        bit ended;
        n             = tdata[r+3];
        e             = r + 4 + n;                   // end tag word
        done_at_start = done_cnt;
        waited        = 0;
        ended         = 1'b0;
        pcmd_fre      = tdata[r+2][0];
        in_valid      = 1'b1;                        // header shows up before the get
        in_dword      = '{data: tdata[r+4], tag: FIS_HEAD};
        @(negedge mclk);
        while (!fis_first_vld && waited < 4) begin
            @(negedge mclk);
            waited++;
        end
        if (!fis_first_vld) report_problem({name, ": fis_first_vld did not rise on the header"});
        if (in_ready !== 1'b0) report_mismatch(name, "in_ready before get", 0, {31'd0, in_ready});
        step_cycle();
        get_valid = 1'b1;
        get_kind  = fis_kind_e'(tdata[r+1][1:0]);
        step_cycle();
        get_valid = 1'b0;
        for (int i = 0; i <= n && !ended; i++) begin
            if (i > 0) begin
                lfsr = lfsr_next(lfsr);
                if (lfsr[0]) begin                   // one idle cycle
                    in_valid = 1'b0;
                    step_cycle();
                end
                in_valid = 1'b1;
                if (i < n) in_dword = '{data: tdata[r+4+i], tag: DATA};
                else in_dword = '{data: 32'd0, tag: in_type_e'(tdata[e][1:0])};
            end
            consumed = 1'b0;
            while (!consumed && !ended) begin
                @(negedge mclk);
                consumed = in_valid && in_ready;
                ended    = !consumed && !get_fis_busy;   // closed early by an overrun
                if (consumed && i < n) ref_cyc_q.push_back(cyc);
                step_cycle();
            end
        end
        in_valid = 1'b0;
        while (done_cnt == done_at_start) step_cycle();  // watchdog bounds this
        repeat (3) step_cycle();                         // room for a stray write
        if (done_cnt - done_at_start != 1) begin
            report_mismatch(name, "get_fis_done pulses", 1, done_cnt - done_at_start);
        end
        check_result(name, e + 1);
    endtask

    task automatic run_cmd(string name, int r);
        case (tdata[r+1])
            0:       set_bsy = 1'b1;
            1:       clear_bsy_drq = 1'b1;
            2:       update_sig = 1'b1;
            3:       update_err_sts = 1'b1;
            default: set_update_sig = 1'b1;
        endcase
        ref_cyc_q.push_back(cyc);
        step_cycle();
        set_bsy        = 1'b0;
        clear_bsy_drq  = 1'b0;
        update_sig     = 1'b0;
        update_err_sts = 1'b0;
        set_update_sig = 1'b0;
        repeat (4) step_cycle();
        check_result(name, r + 5);                   // no data dwords in a command record
    endtask

    // writes and done pulses are read mid-cycle
    always @(negedge mclk) begin
        if (reg_we === 1'b1) begin
            wr_addr_q.push_back(reg_wr.addr);
            wr_data_q.push_back(reg_wr.data);
            wr_cyc_q.push_back(cyc);
        end
        if (get_fis_done === 1'b1) done_cnt++;
    end

    initial begin : watchdog
        wait (limit != 0);
        while (cyc < limit) begin
            @(posedge mclk);
            cyc++;
        end
        $display("ERROR run did not finish within %0d cycles", limit);
        $display("SOME TESTS FAILED");
        $finish;
    end

    initial begin
        in_valid       = 1'b0;
        in_dword       = '0;
        get_valid      = 1'b0;
        get_kind       = RFIS;
        pcmd_fre       = 1'b0;
        update_sig     = 1'b0;
        set_update_sig = 1'b0;
        update_err_sts = 1'b0;
        set_bsy        = 1'b0;
        clear_bsy_drq  = 1'b0;
        $readmemh("tb/fis_testdata.txt", tdata);
        p     = 0;
        total = 0;
        while (p < MEM_WORDS - 4 && tdata[p] !== 32'd0 && !$isunknown(tdata[p])) begin
            n_dw  = tdata[p+3];
            total += n_dw;
            p     += 9 + n_dw + 2 * tdata[p+5+n_dw];
        end
        limit = 20 * total + 200;
        if (total == 0) report_problem("no test records read from tb/fis_testdata.txt");
        wait (hba_rst === 1'b0);
        step_cycle();
        rst_bits = {reg_we, get_fis_busy, get_fis_done, fis_ok, fis_err, fis_ferr,
                    fis_first_vld, sig_available, sig_pending};
        if (rst_bits !== 9'h001) report_mismatch("reset", "status bits", 32'h1, {23'd0, rst_bits});
        p = 0;
        while (p < MEM_WORDS - 4 && tdata[p] !== 32'd0 && !$isunknown(tdata[p])) begin
            n_dw = tdata[p+3];
            tests++;
            if (tdata[p] == 32'd1) begin
                run_fis($sformatf("test %0d %s", tests, kind_names[tdata[p+1][1:0]]), p);
            end else begin
                run_cmd($sformatf("test %0d %s", tests, cmd_names[tdata[p+1]]), p);
            end
            p += 9 + n_dw + 2 * tdata[p+5+n_dw];
        end
        $display("tests run: %0d, errors: %0d", tests, errors);
        if (errors == 0) begin
            $display("ALL TESTS PASSED");
        end else begin
            $display("SOME TESTS FAILED");
        end
        $finish;
    end

endmodule

//--- tb/fis_testdata.txt
// record: code arg fre n | n dwords, header first | end tag | nwr | nwr x (addr data) | tfd pio_es flags
// code 1 FIS (arg 0 rfis 1 psfis 2 sdbfis 3 ignore), code 2 host cmd (arg 0 set_bsy 1 clear_bsy_drq
// 2 update_sig 3 update_err_sts 4 set_update_sig); end tag 2 R_OK 3 R_ERR; all values hex
// flags: bit0 ok, bit1 err, bit2 ferr, bit3 sig_available, bit4 sig_pending; code 0 ends the list
1 0 1 5                                   // rfis, fre on
01505034 a0112233 5a5a0001 000000c4 0000beef
2 5
310 01505034 311 a0112233 312 5a5a0001 313 000000c4 314 0000beef
5034 00 19
1 1 0 5                                   // psfis, fre off, nothing saved
2058205f 11111111 22222222 50000000 00000200
2 0
2058 50 19
1 0 0 5                                   // rfis, fre off but signature pending
12340288 00445566 77777777 00000099 0000abcd
2 5
310 12340288 311 00445566 312 77777777 313 00000099 314 0000abcd
0288 50 19
1 2 1 2                                   // sdbfis ending in R_ERR, sts 88 merged
12344175 deadbeef
3 2
316 12344175 317 deadbeef
41fd 50 1a
2 0 0 0 0 1 048 000041fd 41fd 50 1a       // set_bsy
2 1 0 0 0 1 048 00004175 4175 50 1a       // clear_bsy_drq
2 2 0 0 0 1 049 44556699 4175 50 02       // update_sig
2 2 0 0 0 0 4175 50 02                    // update_sig again, no write
1 3 1 11                                  // ignore, 17 dwords, one past the limit
0000c7a1 00000001 00000002 00000003 00000004 00000005 00000006 00000007 00000008
00000009 0000000a 0000000b 0000000c 0000000d 0000000e 0000000f 00000010
2 0
4175 50 04
1 2 0 2                                   // sdbfis after the overrun, ferr stays
00002040 00000000
2 0
2040 50 05
2 3 0 0 0 1 048 00002040 2040 50 05       // update_err_sts
0

//--- tb/tb_clock_gen.sv
// Clock and reset source for the testbench.
// mclk period is 100 ns, hba_rst stays high over the first two rising edges
// and drops 1 ns after the second one.
`timescale 1ns/1ps

module tb_clock_gen #(
    parameter int HALF_NS = 50           // half of the 100 ns period
) (
    output logic mclk,
    output logic hba_rst
);

    initial begin
        mclk = 1'b0;
        forever #(HALF_NS) mclk = ~mclk;
    end

    initial begin
        hba_rst = 1'b1;
        repeat (2) @(posedge mclk);
        #1;
        hba_rst = 1'b0;                  // released like any other input
    end

endmodule
